/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // datapath and address width
    localparam int xlen = 64;

    // bus id used on this stage's read requests
    localparam logic [3:0] mem_bus_id = 4'd2;

    // machine csr numbers
    localparam logic [11:0] csr_mstatus_addr = 12'd768;
    localparam logic [11:0] csr_mtvec_addr   = 12'd773;
    localparam logic [11:0] csr_mepc_addr    = 12'd833;
    localparam logic [11:0] csr_mcause_addr  = 12'd834;

    // environment call from machine mode
    localparam logic [xlen-1:0] cause_ecall_m = 64'd11;

    typedef enum logic [2:0] {
        op_pass  = 3'd0,
        op_load  = 3'd1,
        op_csrrw = 3'd2,
        op_csrrs = 3'd3,
        op_ecall = 3'd4
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte  = 2'd0,
        size_half  = 2'd1,
        size_word  = 2'd2,
        size_dword = 2'd3
    } load_size_e;

    // one operation from execute
    typedef struct packed {
        mem_op_e         op;
        load_size_e      size;
        logic            is_signed;
        logic [xlen-1:0] src1;       // base reg, or pc for ecall
        logic [xlen-1:0] src2;       // offset, or csr operand
        logic [11:0]     csr_addr;
        logic [xlen-1:0] ex_result;
    } mem_req_t;

    typedef struct packed {
        logic [xlen-1:0] data;
    } wb_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [3:0]      id;
    } rd_req_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        logic [3:0]      id;
    } rd_resp_t;

endpackage

`default_nettype wire

/* logic/load_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module load_unit import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  mem_req_t        req,
    output rd_req_t         rd_req,
    output logic            rd_req_valid,
    input  logic            rd_req_ready,
    input  rd_resp_t        rd_resp,
    input  logic            rd_resp_valid,
    output logic            load_done,
    output logic [xlen-1:0] load_data,
    output logic            busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [xlen-1:0] sum;
    logic [xlen-1:0] addr_q;
    logic [2:0]      offset_q;
    load_size_e      size_q;
    logic            signed_q;

    logic            resp_hit;
    logic [5:0]      shamt;
    logic [xlen-1:0] shifted;
    logic [xlen-1:0] lane;

    assign sum = req.src1 + req.src2;

    // only our own id counts, and only while waiting
    assign resp_hit = (state_q == st_wait) && rd_resp_valid && (rd_resp.id == mem_bus_id);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (start) begin
                    state_d = st_req;
                end
            end
            st_req: begin
                if (rd_req_ready) begin
                    state_d = st_wait;
                end
            end
            st_wait: begin
                if (resp_hit) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= st_idle;
            load_done <= 1'b0;
        end else begin
            state_q   <= state_d;
            load_done <= resp_hit;
        end
    end

    // access attributes, captured once per load
    always_ff @(posedge clk) begin
        if (start && state_q == st_idle) begin
            addr_q   <= {sum[xlen-1:3], 3'b000};
            offset_q <= sum[2:0];
            size_q   <= req.size;
            signed_q <= req.is_signed;
        end
    end

    // move the addressed byte down to bit 0
    assign shamt   = {offset_q, 3'b000};
    assign shifted = rd_resp.data >> shamt;

    always_comb begin
        case (size_q)
            size_byte:  lane = {{(xlen-8){signed_q & shifted[7]}}, shifted[7:0]};
            size_half:  lane = {{(xlen-16){signed_q & shifted[15]}}, shifted[15:0]};
            size_word:  lane = {{(xlen-32){signed_q & shifted[31]}}, shifted[31:0]};
            default:    lane = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (resp_hit) begin
            load_data <= lane;
        end
    end

    assign rd_req.addr  = addr_q;
    assign rd_req.id    = mem_bus_id;
    assign rd_req_valid = (state_q == st_req);
    assign busy         = (state_q != st_idle);

endmodule

`default_nettype wire

/* logic/csr_file.sv */
`default_nettype none
`timescale 1ns/10ps

module csr_file import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            commit,
    input  mem_req_t        req,
    output logic [xlen-1:0] old_value,
    output logic [xlen-1:0] mtvec,
    output logic [xlen-1:0] mepc
);

    logic [xlen-1:0] mstatus_q;
    logic [xlen-1:0] mtvec_q;
    logic [xlen-1:0] mepc_q;
    logic [xlen-1:0] mcause_q;

    logic            wr_en;
    logic [xlen-1:0] wr_data;
    logic            is_ecall;

    // read mux, unknown numbers read as zero
    always_comb begin
        case (req.csr_addr)
            csr_mstatus_addr: old_value = mstatus_q;
            csr_mtvec_addr:   old_value = mtvec_q;
            csr_mepc_addr:    old_value = mepc_q;
            csr_mcause_addr:  old_value = mcause_q;
            default:          old_value = '0;
        endcase
    end

    assign wr_en    = commit && (req.op == op_csrrw || req.op == op_csrrs);
    assign is_ecall = commit && (req.op == op_ecall);

    // csrrs ors into the current value, csrrw replaces it
    always_comb begin
        if (req.op == op_csrrs) begin
            wr_data = old_value | req.src2;
        end else begin
            wr_data = req.src2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= '0;
            mtvec_q   <= '0;
            mepc_q    <= '0;
            mcause_q  <= '0;
        end else if (is_ecall) begin
            mepc_q       <= req.src1;
            mcause_q     <= cause_ecall_m;
            // mpie takes mie, then mie clears
            mstatus_q[7] <= mstatus_q[3];
            mstatus_q[3] <= 1'b0;
        end else if (wr_en) begin
            case (req.csr_addr)
                csr_mstatus_addr: mstatus_q <= wr_data;
                csr_mtvec_addr:   mtvec_q   <= wr_data;
                csr_mepc_addr:    mepc_q    <= wr_data;
                csr_mcause_addr:  mcause_q  <= wr_data;
                default: begin
                    // write to unknown csr is dropped
                end
            endcase
        end
    end

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module mem_stage import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  mem_req_t        in_req,
    input  logic            in_valid,
    output logic            in_ready,
    output wb_t             out_wb,
    output logic            out_valid,
    input  logic            out_ready,
    output rd_req_t         rd_req,
    output logic            rd_req_valid,
    input  logic            rd_req_ready,
    input  rd_resp_t        rd_resp,
    input  logic            rd_resp_valid,
    output logic [xlen-1:0] mtvec,
    output logic [xlen-1:0] mepc
);

    logic            accept;
    logic            is_load;
    logic            is_csr;
    logic            start;
    logic            commit;

    logic            load_busy;
    logic            load_done;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] old_value;
    logic [xlen-1:0] direct_result;

    // hold off while a load is out or the result is stuck
    assign in_ready = !load_busy && !load_done && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;

    assign is_load = (in_req.op == op_load);
    assign is_csr  = (in_req.op == op_csrrw) || (in_req.op == op_csrrs) ||
                     (in_req.op == op_ecall);

    assign start  = accept && is_load;
    assign commit = accept && is_csr;

    load_unit u_load (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .req           (in_req),
        .rd_req        (rd_req),
        .rd_req_valid  (rd_req_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid),
        .load_done     (load_done),
        .load_data     (load_data),
        .busy          (load_busy)
    );

    csr_file u_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .commit    (commit),
        .req       (in_req),
        .old_value (old_value),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

    // results that are ready in the accepting cycle
    always_comb begin
        case (in_req.op)
            op_csrrw: direct_result = old_value;
            op_csrrs: direct_result = old_value;
            op_ecall: direct_result = '0;
            default:  direct_result = in_req.ex_result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load_done) begin
            out_valid <= 1'b1;
        end else if (accept && !is_load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // data only moves when a new result arrives
    always_ff @(posedge clk) begin
        if (load_done) begin
            out_wb.data <= load_data;
        end else if (accept && !is_load) begin
            out_wb.data <= direct_result;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mem_model.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_mem_model import mem_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  rd_req_t  rd_req,
    input  logic     rd_req_valid,
    output logic     rd_req_ready,
    output rd_resp_t rd_resp,
    output logic     rd_resp_valid
);

    logic            pending;
    logic [63:0]     hold_addr;
    logic [3:0]      hold_id;
    int              count;

    // each doubleword is a function of its whole address
    function automatic logic [63:0] word_at(input logic [63:0] addr);
        return addr * 64'h9E37_79B9_7F4A_7C15 + 64'hA5A5_0F0F_3C3C_9696;
    endfunction

    initial begin
        rd_req_ready  = 1'b0;
        rd_resp       = '0;
        rd_resp_valid = 1'b0;
        pending       = 1'b0;
        hold_addr     = '0;
        hold_id       = '0;
        count         = 0;
        forever begin
            // a request seen here transfers at the coming edge
            @(negedge clk);
            if (rst_n && rd_req_valid && rd_req_ready && !pending) begin
                pending   = 1'b1;
                hold_addr = rd_req.addr;
                hold_id   = rd_req.id;
                count     = 1 + ($urandom % 6);
            end
            @(posedge clk);
            #1;
            rd_resp_valid = 1'b0;
            if (pending && count == 1) begin
                rd_resp_valid = 1'b1;
                rd_resp.data  = word_at(hold_addr);
                rd_resp.id    = hold_id;
                pending       = 1'b0;
            end else if (pending) begin
                count = count - 1;
                // traffic for another master on the shared response bus
                if ($urandom % 2 == 0) begin
                    rd_resp_valid = 1'b1;
                    rd_resp.data  = {$urandom, $urandom};
                    rd_resp.id    = 4'd5;
                end
            end
            rd_req_ready = !pending && ($urandom % 3 != 0);
        end
    end

endmodule

`default_nettype wire

/* tb/tb_mem_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_mem_stage import mem_pkg::*; ();

    localparam int clk_period = 8;
    // reset reads, pass, loads, csr ops, unknown csr, ecall sequence
    localparam int num_ops = 5 + 20 + 60 + 12 + 2 + 6;
    localparam logic [11:0] csr_list [5] = '{csr_mstatus_addr, csr_mtvec_addr,
                                            csr_mepc_addr, csr_mcause_addr, 12'h7c0};

    logic            clk = 1'b0;
    logic            rst_n;
    mem_req_t        in_req;
    logic            in_valid;
    logic            in_ready;
    wb_t             out_wb;
    logic            out_valid;
    logic            out_ready;
    rd_req_t         rd_req;
    logic            rd_req_valid;
    logic            rd_req_ready;
    rd_resp_t        rd_resp;
    logic            rd_resp_valid;
    logic [63:0]     mtvec;
    logic [63:0]     mepc;

    // reference state
    logic [63:0]     exp_q [$];
    string           name_q [$];
    logic [63:0]     exp_addr = '0;
    logic [63:0]     m_mstatus = '0;
    logic [63:0]     m_mtvec = '0;
    logic [63:0]     m_mepc = '0;
    logic [63:0]     m_mcause = '0;
    int              n_checked = 0;
    logic [63:0]     got_exp;
    string           got_name;

    mem_stage DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_req        (in_req),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_wb        (out_wb),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .rd_req        (rd_req),
        .rd_req_valid  (rd_req_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid),
        .mtvec         (mtvec),
        .mepc          (mepc)
    );

    tb_mem_model u_mem (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_req        (rd_req),
        .rd_req_valid  (rd_req_valid),
        .rd_req_ready  (rd_req_ready),
        .rd_resp       (rd_resp),
        .rd_resp_valid (rd_resp_valid)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    // same fill as the memory model
    function automatic logic [63:0] word_at(input logic [63:0] addr);
        return addr * 64'h9E37_79B9_7F4A_7C15 + 64'hA5A5_0F0F_3C3C_9696;
    endfunction

    // pick bytes from the offset up, then extend from the top bit
    function automatic logic [63:0] load_expect(input logic [63:0] word, input logic [2:0] off,
                                                input load_size_e sz, input logic sgn);
        logic [63:0] v;
        int          nbytes;
        logic        msb;
        v      = '0;
        nbytes = 1 << sz;
        for (int i = 0; i < nbytes; i++) begin
            v[i*8 +: 8] = word[(off + i)*8 +: 8];
        end
        msb = v[nbytes*8 - 1];
        for (int i = nbytes*8; i < 64; i++) begin
            v[i] = sgn & msb;
        end
        return v;
    endfunction

    function automatic logic [63:0] csr_value(input logic [11:0] num);
        case (num)
            csr_mstatus_addr: return m_mstatus;
            csr_mtvec_addr:   return m_mtvec;
            csr_mepc_addr:    return m_mepc;
            csr_mcause_addr:  return m_mcause;
            default:          return '0;
        endcase
    endfunction

    task automatic csr_update(input logic [11:0] num, input logic [63:0] value);
        case (num)
            csr_mstatus_addr: m_mstatus = value;
            csr_mtvec_addr:   m_mtvec = value;
            csr_mepc_addr:    m_mepc = value;
            csr_mcause_addr:  m_mcause = value;
            default: begin
            end
        endcase
    endtask

    function automatic mem_req_t build_req(input mem_op_e op, input logic [11:0] num,
                                           input logic [63:0] operand);
        mem_req_t    r;
        logic [31:0] w;
        w           = $urandom;
        r.op        = op;
        r.size      = load_size_e'(w[1:0]);
        r.is_signed = w[2];
        r.src1      = rand64();
        r.src2      = operand;
        r.csr_addr  = num;
        r.ex_result = rand64();
        return r;
    endfunction

    task automatic predict_op(input mem_req_t r, input string name);
        logic [63:0] sum;
        logic [63:0] old;
        logic [63:0] result;
        sum    = r.src1 + r.src2;
        old    = csr_value(r.csr_addr);
        result = '0;
        case (r.op)
            op_load: begin
                exp_addr = {sum[63:3], 3'b000};
                result   = load_expect(word_at(exp_addr), sum[2:0], r.size, r.is_signed);
            end
            op_csrrw: begin
                result = old;
                csr_update(r.csr_addr, r.src2);
            end
            op_csrrs: begin
                result = old;
                csr_update(r.csr_addr, old | r.src2);
            end
            op_ecall: begin
                m_mepc       = r.src1;
                m_mcause     = 64'd11;
                m_mstatus[7] = m_mstatus[3];
                m_mstatus[3] = 1'b0;
            end
            default: result = r.ex_result;
        endcase
        exp_q.push_back(result);
        name_q.push_back(name);
    endtask

    // called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic issue_op(input mem_req_t r, input string name);
        logic took;
        in_req   = r;
        in_valid = 1'b1;
        took     = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = in_ready;
        end
        predict_op(r, name);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        // trap vector and return pc ports follow the csr state
        assert (mtvec == m_mtvec)
            else fail_run($sformatf("ERR %s_mtvec: expected %h, actual %h",
                                    name, m_mtvec, mtvec));
        assert (mepc == m_mepc)
            else fail_run($sformatf("ERR %s_mepc: expected %h, actual %h",
                                    name, m_mepc, mepc));
    endtask

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_ready = ($urandom % 4) != 0;
        end
    end

    // every output transfer against the queue head
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("a result came out with no operation outstanding");
            end else begin
                got_exp   = exp_q.pop_front();
                got_name  = name_q.pop_front();
                n_checked = n_checked + 1;
                assert (out_wb.data == got_exp)
                    else fail_run($sformatf("ERR %s: expected %h, actual %h",
                                            got_name, got_exp, out_wb.data));
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && rd_req_valid) begin
            assert (rd_req.addr == exp_addr && rd_req.id == 4'd2)
                else fail_run($sformatf("ERR rd_req: expected %h id 2, actual %h id %0d",
                                        exp_addr, rd_req.addr, rd_req.id));
            assert (!in_ready) else fail_run("in_ready high while a load is in progress");
        end
        if (rst_n && out_valid && !out_ready) begin
            assert (!in_ready) else fail_run("in_ready high while the result is held");
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
        else fail_run("read request dropped or changed before rd_req_ready");

    out_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_wb))
        else fail_run("output result dropped or changed before out_ready");

    initial begin
        #(num_ops * 40 * clk_period);
        fail_run("watchdog expired before all operations completed");
    end

    initial begin
        mem_req_t    r;
        logic [63:0] target;
        void'($urandom(80614));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (!out_valid && !rd_req_valid && in_ready)
            else fail_run("handshake outputs not in their reset state");
        @(posedge clk);
        #1;

        for (int i = 0; i < 5; i++) begin
            issue_op(build_req(op_csrrs, csr_list[i], '0), "reset_read");
        end
        for (int i = 0; i < 20; i++) begin
            issue_op(build_req(op_pass, 12'h000, rand64()), "pass");
        end

        // aligned offsets for each width, both extensions
        for (int rep = 0; rep < 2; rep++) begin
            for (int sz = 0; sz < 4; sz++) begin
                for (int off = 0; off < 8; off += (1 << sz)) begin
                    for (int sg = 0; sg < 2; sg++) begin
                        r           = build_req(op_load, 12'h000, rand64());
                        r.size      = load_size_e'(sz[1:0]);
                        r.is_signed = sg[0];
                        target      = rand64();
                        target[2:0] = off[2:0];
                        r.src1      = target - r.src2;
                        issue_op(r, $sformatf("load_s%0d_o%0d_x%0d", sz, off, sg));
                    end
                end
            end
        end

        for (int i = 0; i < 4; i++) begin
            issue_op(build_req(op_csrrw, csr_list[i], rand64()), "csrrw");
            issue_op(build_req(op_csrrs, csr_list[i], rand64()), "csrrs");
            issue_op(build_req(op_csrrs, csr_list[i], '0), "csr_read");
        end
        issue_op(build_req(op_csrrw, 12'h7c0, rand64()), "unknown_write");
        issue_op(build_req(op_csrrs, 12'h7c0, '0), "unknown_read");

        // mie set, so the ecall has a bit to move
        issue_op(build_req(op_csrrw, csr_mstatus_addr, rand64() | 64'h8), "mstatus_mie");
        issue_op(build_req(op_ecall, 12'h000, '0), "ecall");
        issue_op(build_req(op_csrrs, csr_mcause_addr, '0), "ecall_mcause");
        issue_op(build_req(op_csrrs, csr_mstatus_addr, '0), "ecall_mstatus");
        // mie now clear, so mpie has to drop back to zero
        issue_op(build_req(op_ecall, 12'h000, '0), "ecall_again");
        issue_op(build_req(op_csrrs, csr_mstatus_addr, '0), "ecall_again_mstatus");

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (n_checked == num_ops) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run($sformatf("%0d results checked, %0d expected", n_checked, num_ops));
        end
    end

endmodule

`default_nettype wire

/* project.f */
logic/mem_pkg.sv
logic/load_unit.sv
logic/csr_file.sv
logic/mem_stage.sv
tb/tb_mem_model.sv
tb/tb_mem_stage.sv

/* run_sim.sh */
#!/bin/sh
# build the memory stage testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mem_stage \
    -f project.f --Mdir obj_dir -o tb_mem_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_mem_stage 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
